// ==== filelist.f ====
+incdir+source
source/kbd_xlat_pkg.sv
source/kbd_frame_receiver.sv
source/scan_code_table.sv
source/break_prefix_tracker.sv
source/xt_frame_sender.sv
source/kbd_xlat_top.sv
verification/scan_code_model.sv
verification/kbd_xlat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the translator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
	--top-module kbd_xlat_tb -o kbd_xlat_sim

out=$(./obj_dir/kbd_xlat_sim)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== source/break_prefix_tracker.sv ====
// --------------------------------------------------------------------------
// Tracks the set 2 break prefix between keyboard frames
// suppress is combinational and only meaningful while rx_valid is high
// break_flag changes one edge after the byte that sets or clears it
// --------------------------------------------------------------------------
`default_nettype none

`include "kbd_xlat_defs.svh"

module break_prefix_tracker
	import kbd_xlat_pkg::*;
(
	input  wire             latch,
	input  wire             arst_n,
	input  wire scan_byte_t rx_byte,
	input  wire             rx_valid,
	output logic            suppress,    // Current byte is the prefix
	output logic            break_flag   // Prefix pending for next code
);

	assign suppress = (rx_byte == `KBD_BREAK_PREFIX);

	// Set by a prefix, cleared by the code it applies to
	// Back to back prefixes just keep it set
	always_ff @(posedge latch or negedge arst_n) begin
		if (!arst_n)
			break_flag <= 1'b0;
		else if (rx_valid)
			break_flag <= suppress;
	end

endmodule

`default_nettype wire

// ==== source/kbd_frame_receiver.sv ====
// --------------------------------------------------------------------------
// Keyboard frame deserializer
// Samples kbd_data once per latch edge with no oversampling
// Frame is start 0, eight data bits LSB first, stop 1
// A bad stop bit drops the frame without any error output
// --------------------------------------------------------------------------
`default_nettype none

`include "kbd_xlat_defs.svh"

module kbd_frame_receiver
	import kbd_xlat_pkg::*;
(
	input  wire        latch,
	input  wire        arst_n,
	input  wire        kbd_data,   // Idles high
	output scan_byte_t rx_byte,
	output logic       rx_valid
);

	localparam int CNT_W = $clog2(`KBD_DATA_BITS);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`KBD_DATA_BITS - 1);

	rx_state_e        state;
	logic [CNT_W-1:0] bit_cnt;

	// Control path
	always_ff @(posedge latch or negedge arst_n) begin
		if (!arst_n) begin
			state    <= RX_IDLE;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0; // Single cycle strobe
			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					if (!kbd_data)
						state <= RX_DATA; // Start bit seen
				end
				RX_DATA: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == LAST_BIT)
						state <= RX_STOP;
				end
				RX_STOP: begin
					// Only a high stop bit makes the byte visible
					rx_valid <= kbd_data;
					state    <= RX_IDLE;
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// Data shifts in from the top so bit 0 ends up first received
	always_ff @(posedge latch) begin
		if (state == RX_DATA)
			rx_byte <= {kbd_data, rx_byte[`KBD_DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

// ==== source/kbd_xlat_defs.svh ====
// --------------------------------------------------------------------------
// Protocol constants for the keyboard and PC serial frames
// Both links move one bit per clock edge with no parity bit
// --------------------------------------------------------------------------
`ifndef KBD_XLAT_DEFS_SVH
`define KBD_XLAT_DEFS_SVH

// Set 2 break prefix, never forwarded to the PC
`define KBD_BREAK_PREFIX 8'hF0

`define KBD_BREAK_BIT 8'h80 // Set 1 release marker

// Data bits per frame on both links, LSB first
`define KBD_DATA_BITS 8

`endif

// ==== source/kbd_xlat_pkg.sv ====
// --------------------------------------------------------------------------
// Shared types for the set 2 to set 1 scan code translator
// Every code is a single byte and extended prefixes are not decoded
// Receiver and sender FSMs both use two-bit state encodings
// --------------------------------------------------------------------------
`default_nettype none

package kbd_xlat_pkg;

	typedef logic [7:0] scan_byte_t; // One scan code, either set

	// Keyboard side deserializer
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// PC side serializer
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

`default_nettype wire

// ==== source/kbd_xlat_top.sv ====
// --------------------------------------------------------------------------
// Keyboard set 2 to PC set 1 translator, top level
// Single clock latch with asynchronous active low reset
// Keyboard to PC direction only, no command path or parity
// pc_data start bit follows the keyboard stop bit by two edges
// --------------------------------------------------------------------------
`default_nettype none

module kbd_xlat_top
	import kbd_xlat_pkg::*;
(
	input  wire  latch,
	input  wire  arst_n,
	input  wire  kbd_data,
	output logic pc_data
);

	scan_byte_t rx_byte;
	scan_byte_t xlat_byte;
	logic       rx_valid;
	logic       suppress;
	logic       break_flag;

	kbd_frame_receiver kbd_frame_receiver_inst (
		.latch    (latch),
		.arst_n   (arst_n),
		.kbd_data (kbd_data),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	// Lookup and prefix tracking both work on the received byte
	scan_code_table scan_code_table_inst (
		.rx_byte   (rx_byte),
		.xlat_byte (xlat_byte)
	);

	break_prefix_tracker break_prefix_tracker_inst (
		.latch      (latch),
		.arst_n     (arst_n),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.suppress   (suppress),
		.break_flag (break_flag)
	);

	xt_frame_sender xt_frame_sender_inst (
		.latch      (latch),
		.arst_n     (arst_n),
		.rx_valid   (rx_valid),
		.xlat_byte  (xlat_byte),
		.suppress   (suppress),
		.break_flag (break_flag),
		.pc_data    (pc_data)
	);

endmodule

`default_nettype wire

// ==== source/scan_code_table.sv ====
// --------------------------------------------------------------------------
// Set 2 to set 1 translation as done by the 8042 controller
// Purely combinational, so the result follows rx_byte directly
// Codes above 0x7F map to themselves except 0x83 and 0x84
// E0, E1 and F0 therefore pass through unchanged
// --------------------------------------------------------------------------
`default_nettype none

module scan_code_table
	import kbd_xlat_pkg::*;
(
	input  wire scan_byte_t rx_byte,
	output scan_byte_t      xlat_byte
);

	always_comb begin
		case (rx_byte)
			8'h00: xlat_byte = 8'hff; // Keyboard error code
			8'h01: xlat_byte = 8'h43;
			8'h02: xlat_byte = 8'h41;
			8'h03: xlat_byte = 8'h3f;
			8'h04: xlat_byte = 8'h3d;
			8'h05: xlat_byte = 8'h3b;
			8'h06: xlat_byte = 8'h3c;
			8'h07: xlat_byte = 8'h58;
			8'h08: xlat_byte = 8'h64;
			8'h09: xlat_byte = 8'h44;
			8'h0a: xlat_byte = 8'h42;
			8'h0b: xlat_byte = 8'h40;
			8'h0c: xlat_byte = 8'h3e;
			8'h0d: xlat_byte = 8'h0f;
			8'h0e: xlat_byte = 8'h29;
			8'h0f: xlat_byte = 8'h59;
			8'h10: xlat_byte = 8'h65;
			8'h11: xlat_byte = 8'h38;
			8'h12: xlat_byte = 8'h2a; // Left shift
			8'h13: xlat_byte = 8'h70;
			8'h14: xlat_byte = 8'h1d;
			8'h15: xlat_byte = 8'h10;
			8'h16: xlat_byte = 8'h02;
			8'h17: xlat_byte = 8'h5a;
			8'h18: xlat_byte = 8'h66;
			8'h19: xlat_byte = 8'h71;
			8'h1a: xlat_byte = 8'h2c;
			8'h1b: xlat_byte = 8'h1f;
			8'h1c: xlat_byte = 8'h1e;
			8'h1d: xlat_byte = 8'h11;
			8'h1e: xlat_byte = 8'h03;
			8'h1f: xlat_byte = 8'h5b;
			8'h20: xlat_byte = 8'h67;
			8'h21: xlat_byte = 8'h2e;
			8'h22: xlat_byte = 8'h2d;
			8'h23: xlat_byte = 8'h20;
			8'h24: xlat_byte = 8'h12;
			8'h25: xlat_byte = 8'h05;
			8'h26: xlat_byte = 8'h04;
			8'h27: xlat_byte = 8'h5c;
			8'h28: xlat_byte = 8'h68;
			8'h29: xlat_byte = 8'h39; // Space bar
			8'h2a: xlat_byte = 8'h2f;
			8'h2b: xlat_byte = 8'h21;
			8'h2c: xlat_byte = 8'h14;
			8'h2d: xlat_byte = 8'h13;
			8'h2e: xlat_byte = 8'h06;
			8'h2f: xlat_byte = 8'h5d;
			8'h30: xlat_byte = 8'h69;
			8'h31: xlat_byte = 8'h31;
			8'h32: xlat_byte = 8'h30;
			8'h33: xlat_byte = 8'h23;
			8'h34: xlat_byte = 8'h22;
			8'h35: xlat_byte = 8'h15;
			8'h36: xlat_byte = 8'h07;
			8'h37: xlat_byte = 8'h5e;
			8'h38: xlat_byte = 8'h6a;
			8'h39: xlat_byte = 8'h72;
			8'h3a: xlat_byte = 8'h32;
			8'h3b: xlat_byte = 8'h24;
			8'h3c: xlat_byte = 8'h16;
			8'h3d: xlat_byte = 8'h08;
			8'h3e: xlat_byte = 8'h09;
			8'h3f: xlat_byte = 8'h5f;
			8'h40: xlat_byte = 8'h6b;
			8'h41: xlat_byte = 8'h33;
			8'h42: xlat_byte = 8'h25;
			8'h43: xlat_byte = 8'h17;
			8'h44: xlat_byte = 8'h18;
			8'h45: xlat_byte = 8'h0b;
			8'h46: xlat_byte = 8'h0a;
			8'h47: xlat_byte = 8'h60;
			8'h48: xlat_byte = 8'h6c;
			8'h49: xlat_byte = 8'h34;
			8'h4a: xlat_byte = 8'h35;
			8'h4b: xlat_byte = 8'h26;
			8'h4c: xlat_byte = 8'h27;
			8'h4d: xlat_byte = 8'h19;
			8'h4e: xlat_byte = 8'h0c;
			8'h4f: xlat_byte = 8'h61;
			8'h50: xlat_byte = 8'h6d;
			8'h51: xlat_byte = 8'h73;
			8'h52: xlat_byte = 8'h28;
			8'h53: xlat_byte = 8'h74;
			8'h54: xlat_byte = 8'h1a;
			8'h55: xlat_byte = 8'h0d;
			8'h56: xlat_byte = 8'h62;
			8'h57: xlat_byte = 8'h6e;
			8'h58: xlat_byte = 8'h3a; // Caps lock
			8'h59: xlat_byte = 8'h36;
			8'h5a: xlat_byte = 8'h1c; // Enter
			8'h5b: xlat_byte = 8'h1b;
			8'h5c: xlat_byte = 8'h75;
			8'h5d: xlat_byte = 8'h2b;
			8'h5e: xlat_byte = 8'h63;
			8'h5f: xlat_byte = 8'h76;
			8'h60: xlat_byte = 8'h55;
			8'h61: xlat_byte = 8'h56;
			8'h62: xlat_byte = 8'h77;
			8'h63: xlat_byte = 8'h78;
			8'h64: xlat_byte = 8'h79;
			8'h65: xlat_byte = 8'h7a;
			8'h66: xlat_byte = 8'h0e;
			8'h67: xlat_byte = 8'h7b;
			8'h68: xlat_byte = 8'h7c;
			8'h69: xlat_byte = 8'h4f;
			8'h6a: xlat_byte = 8'h7d;
			8'h6b: xlat_byte = 8'h4b;
			8'h6c: xlat_byte = 8'h47;
			8'h6d: xlat_byte = 8'h7e;
			8'h6e: xlat_byte = 8'h7f;
			8'h6f: xlat_byte = 8'h6f;
			// Keypad and escape row
			8'h70: xlat_byte = 8'h52;
			8'h71: xlat_byte = 8'h53;
			8'h72: xlat_byte = 8'h50;
			8'h73: xlat_byte = 8'h4c;
			8'h74: xlat_byte = 8'h4d;
			8'h75: xlat_byte = 8'h48;
			8'h76: xlat_byte = 8'h01;
			8'h77: xlat_byte = 8'h45;
			8'h78: xlat_byte = 8'h57;
			8'h79: xlat_byte = 8'h4e;
			8'h7a: xlat_byte = 8'h51;
			8'h7b: xlat_byte = 8'h4a;
			8'h7c: xlat_byte = 8'h37;
			8'h7d: xlat_byte = 8'h49;
			8'h7e: xlat_byte = 8'h46;
			8'h7f: xlat_byte = 8'h54;
			// Only two high codes are remapped
			8'h83: xlat_byte = 8'h41; // F7
			8'h84: xlat_byte = 8'h54;
			default: xlat_byte = rx_byte;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/xt_frame_sender.sv ====
// --------------------------------------------------------------------------
// PC side serializer, one bit per latch edge with registered output
// Frame is start 0, eight data bits LSB first, stop 1
// Start bit leaves one edge after the byte is taken
// A new byte is only taken in idle or during the stop bit
// --------------------------------------------------------------------------
`default_nettype none

`include "kbd_xlat_defs.svh"

module xt_frame_sender
	import kbd_xlat_pkg::*;
(
	input  wire             latch,
	input  wire             arst_n,
	input  wire             rx_valid,
	input  wire scan_byte_t xlat_byte,
	input  wire             suppress,
	input  wire             break_flag,
	output logic            pc_data     // Idles high
);

	localparam int CNT_W = $clog2(`KBD_DATA_BITS);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`KBD_DATA_BITS - 1);

	tx_state_e        state;
	logic [CNT_W-1:0] bit_cnt;
	scan_byte_t       shift_q;
	scan_byte_t       merged;
	logic             accept;

	// Fold a pending break into bit 7
	assign merged = break_flag ? (xlat_byte | `KBD_BREAK_BIT) : xlat_byte;

	assign accept = rx_valid && !suppress && (state == TX_IDLE || state == TX_STOP);

	always_ff @(posedge latch or negedge arst_n) begin
		if (!arst_n) begin
			state   <= TX_IDLE;
			bit_cnt <= '0;
			pc_data <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					pc_data <= 1'b1;
					if (accept)
						state <= TX_START;
				end
				TX_START: begin
					pc_data <= 1'b0;
					bit_cnt <= '0;
					state   <= TX_DATA;
				end
				TX_DATA: begin
					pc_data <= shift_q[0];
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == LAST_BIT)
						state <= TX_STOP;
				end
				TX_STOP: begin
					pc_data <= 1'b1;
					// Back to back frames when keyboard gap is zero
					state <= accept ? TX_START : TX_IDLE;
				end
				default: begin
					state   <= TX_IDLE;
					pc_data <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge latch) begin
		if (accept)
			shift_q <= merged;
		else if (state == TX_DATA)
			shift_q <= {1'b0, shift_q[`KBD_DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

// ==== verification/kbd_xlat_tb.sv ====
// --------------------------------------------------------------------------
// Testbench for the keyboard scan code translator
// Keyboard frames come from a fixed seed and go through scan_code_model
// PC frames are decoded on the falling edge where pc_data is stable
// Watchdog limit scales with the number of keyboard frames
// --------------------------------------------------------------------------
`default_nettype none

`include "kbd_xlat_defs.svh"

module kbd_xlat_tb
	import kbd_xlat_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 4;
	localparam int DIRECTED_FRAMES = 144;
	localparam int RANDOM_FRAMES   = 300;
	localparam int NUM_FRAMES      = DIRECTED_FRAMES + RANDOM_FRAMES;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 16 + 100;

	logic       latch;
	logic       arst_n;
	logic       kbd_data;
	logic       pc_data;

	logic       frame_done; // Model side of each keyboard frame
	scan_byte_t frame_byte;
	logic       stop_ok;
	logic       exp_valid;
	scan_byte_t exp_byte;

	scan_byte_t exp_q[$];
	integer     seed = 32'h22aa_2894;
	int         err_cnt = 0;
	int         pushed_cnt = 0;
	int         checked_cnt = 0;
	int         pc_frame_cnt = 0; // Every decoded PC frame, expected or not

	kbd_xlat_top kbd_xlat_top_inst (
		.latch    (latch),
		.arst_n   (arst_n),
		.kbd_data (kbd_data),
		.pc_data  (pc_data)
	);

	scan_code_model scan_code_model_inst (
		.latch      (latch),
		.arst_n     (arst_n),
		.frame_done (frame_done),
		.frame_byte (frame_byte),
		.stop_ok    (stop_ok),
		.exp_valid  (exp_valid),
		.exp_byte   (exp_byte)
	);

	initial begin
		latch = 1'b0;
		forever #(CLK_PERIOD / 2) latch = ~latch;
	end

	task automatic drive_bit(input logic value);
		@(negedge latch);
		kbd_data   = value;
		frame_done = 1'b0;
	endtask

	task automatic send_frame(input scan_byte_t code, input logic stop_bit);
		drive_bit(1'b0); // Start bit
		for (int i = 0; i < `KBD_DATA_BITS; i++)
			drive_bit(code[i]);
		drive_bit(stop_bit);
		// Model takes the frame on the edge that samples the stop bit
		frame_byte = code;
		stop_ok    = stop_bit;
		frame_done = 1'b1;
	endtask

	// Idle gap of 0 to 5 cycles before the frame
	task automatic send_with_gap(input scan_byte_t code, input logic stop_bit);
		int gap;
		gap = int'($unsigned($random(seed)) % 6);
		repeat (gap)
			drive_bit(1'b1);
		send_frame(code, stop_bit);
	endtask

	task automatic expect_idle_line(input int cycles);
		repeat (cycles) begin
			@(negedge latch);
			if (pc_data !== 1'b1) begin
				err_cnt++;
				$display("Fail at %0t: pc_data got %b, expected 1", $time, pc_data);
			end
		end
	endtask

	initial begin : expect_collector
		forever begin
			@(negedge latch);
			if (exp_valid) begin
				exp_q.push_back(exp_byte);
				pushed_cnt++;
			end
		end
	end

	initial begin : pc_monitor
		scan_byte_t got;
		scan_byte_t want;
		logic       stop_bit;
		forever begin
			@(negedge latch);
			if (arst_n === 1'b1 && pc_data === 1'b0) begin
				for (int i = 0; i < `KBD_DATA_BITS; i++) begin
					@(negedge latch);
					got[i] = pc_data;
				end
				@(negedge latch);
				stop_bit = pc_data;
				pc_frame_cnt++;
				if (stop_bit !== 1'b1) begin
					err_cnt++;
					$display("Fail at %0t: pc_data stop bit got %b, expected 1",
						$time, stop_bit);
				end
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("Error at %0t: PC frame %02h sent with nothing expected",
						$time, got);
				end else begin
					want = exp_q.pop_front();
					checked_cnt++;
					if (got !== want) begin
						err_cnt++;
						$display("Fail at %0t: pc_data byte got %02h, expected %02h",
							$time, got, want);
					end
				end
			end
		end
	end

	initial begin : stimulus
		scan_byte_t code;
		logic       stop_bit;
		arst_n     = 1'b0;
		kbd_data   = 1'b1;
		frame_done = 1'b0;
		frame_byte = '0;
		stop_ok    = 1'b0;
		expect_idle_line(RESET_CYCLES);
		arst_n = 1'b1;
		expect_idle_line(4);
		send_with_gap(8'h1c, 1'b0); // Bad frame, line stays idle
		for (int c = 0; c < 128; c++)
			send_with_gap(scan_byte_t'(c), 1'b1);
		send_with_gap(8'h83, 1'b1);
		send_with_gap(8'h84, 1'b1);
		// Break prefix handling
		send_with_gap(`KBD_BREAK_PREFIX, 1'b1);
		send_with_gap(8'h1c, 1'b1);
		repeat (3)
			send_with_gap(`KBD_BREAK_PREFIX, 1'b1);
		send_with_gap(8'h5a, 1'b1);
		send_with_gap(`KBD_BREAK_PREFIX, 1'b1);
		send_with_gap(8'h12, 1'b0);             // Break stays pending
		send_with_gap(8'h29, 1'b1);
		send_with_gap(`KBD_BREAK_PREFIX, 1'b0); // Dropped prefix
		send_with_gap(8'h76, 1'b1);
		send_with_gap(`KBD_BREAK_PREFIX, 1'b1);
		send_with_gap(8'h83, 1'b1);
		for (int n = 0; n < RANDOM_FRAMES; n++) begin
			if ($unsigned($random(seed)) % 4 == 0)
				code = `KBD_BREAK_PREFIX;
			else
				code = scan_byte_t'($random(seed));
			stop_bit = ($unsigned($random(seed)) % 8) != 0; // Some framing errors
			send_with_gap(code, stop_bit);
		end
		repeat (2)
			drive_bit(1'b1);
		while (exp_q.size() != 0)
			drive_bit(1'b1);
		repeat (24)
			drive_bit(1'b1); // Room for a stray extra frame
		if (pc_frame_cnt != pushed_cnt) begin
			err_cnt++;
			$display("Error: %0d expected bytes but %0d PC frames decoded",
				pushed_cnt, pc_frame_cnt);
		end
		$display("Errors: %0d  PC frames checked: %0d of %0d  keyboard frames: %0d",
			err_cnt, checked_cnt, pushed_cnt, NUM_FRAMES);
		if (err_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge latch);
		$display("Error: watchdog expired after %0d cycles, a PC frame is missing",
			WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/scan_code_model.sv ====
// --------------------------------------------------------------------------
// Reference model of the set 2 to set 1 translation
// Takes one keyboard frame per frame_done strobe
// Frames with a low stop bit change nothing
// Expected PC byte appears one edge after the strobe
// --------------------------------------------------------------------------
`default_nettype none

`include "kbd_xlat_defs.svh"

module scan_code_model
	import kbd_xlat_pkg::*;
(
	input  wire             latch,
	input  wire             arst_n,
	input  wire             frame_done,  // One cycle per keyboard frame
	input  wire scan_byte_t frame_byte,
	input  wire             stop_ok,
	output logic            exp_valid,
	output scan_byte_t      exp_byte
);

	timeunit 1ns;
	timeprecision 100ps;

	// Standard 8042 table for codes 0x00 to 0x7F, eight per row
	localparam scan_byte_t SET1_LUT [0:127] = '{
		8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	logic pending; // Break prefix seen, waiting for its code

	function automatic scan_byte_t to_set1(input scan_byte_t code);
		if (code < 8'h80)
			return SET1_LUT[code[6:0]];
		else if (code == 8'h83)
			return 8'h41;
		else if (code == 8'h84)
			return 8'h54;
		return code; // E0, E1, F0 and the rest map to themselves
	endfunction

	always_ff @(posedge latch or negedge arst_n) begin
		if (!arst_n) begin
			pending   <= 1'b0;
			exp_valid <= 1'b0;
			exp_byte  <= '0;
		end else begin
			exp_valid <= 1'b0;
			if (frame_done && stop_ok) begin
				if (frame_byte == `KBD_BREAK_PREFIX) begin
					pending <= 1'b1; // Repeats just keep it set
				end else begin
					exp_valid <= 1'b1;
					exp_byte  <= to_set1(frame_byte) | (pending ? `KBD_BREAK_BIT : 8'h00);
					pending   <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire
